/* mipsCore.f */
+incdir+logic
logic/mipsIsaPkg.sv
logic/mipsCtrlPkg.sv
logic/alu.sv
logic/registerFile.sv
logic/pcCounter.sv
logic/mainDecoder.sv
logic/mipsCore.sv
testbench/mipsCore_sva.sv
testbench/mipsCoreTb.sv

/* Makefile */
# Verilator build and run for the single-cycle MIPS core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mipsCoreTb
FILELIST  ?= mipsCore.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation output holds the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/mipsCore_input.txt */
// hex words for $readmemh: @00 program, @20 halt byte address, @21 preload word address and value,
// @23 expected store count, @24 on expected stores in order, word address then data
@00
8C010040 00011022 00211820 00222024 // lw r1,0x40(r0); sub r2,r0,r1; add r3,r1,r1; and r4,r1,r2
00222825 0041302A 0022382A AC030000 // or r5,r1,r2; slt r6,r2,r1; slt r7,r1,r2; sw r3,0
AC020004 AC040008 AC05000C AC060010 // sw r2,4; sw r4,8; sw r5,12; sw r6,16
AC070014 00210020 AC000018 10C70001 // sw r7,20; add r0,r1,r1; sw r0,24; beq r6,r7 not taken
AC01001C 10210001 AC010020 AC040024 // sw r1,28; beq r1,r1 taken; sw r1,32 skipped; sw r4,36
08000014                            // j 0x50, jumps to itself
@20
00000050 00000010 0F0F1234 00000009
00000000 1E1E2468  00000001 F0F0EDCC  00000002 00000004  00000003 FFFFFFFC
00000004 00000001  00000005 00000000  00000006 00000000  00000007 0F0F1234
00000009 00000004

/* testbench/mipsCoreTb.sv */
// reads testbench/mipsCore_input.txt relative to the project root; program must fit 32 words
`timescale 1ns/1ps
`include "mipsCore_defines.svh"

module mipsCoreTb;
    import mipsCtrlPkg::*;

    // word indices into the input file
    localparam int haltIdx      = 32;
    localparam int preloadIdx   = 33;
    localparam int storeCntIdx  = 35;
    localparam int storeBaseIdx = 36;
    localparam int timeoutLimit = 200;

    logic                        Clk;
    logic                        reset;
    logic [`MIPS_DATA_WIDTH-1:0] instrAddr;
    logic [`MIPS_DATA_WIDTH-1:0] instr;
    memReq_t                     memReq;
    logic [`MIPS_DATA_WIDTH-1:0] memReadData;

    logic [31:0] inputWords [0:63];
    logic [31:0] instrRom [0:31];
    logic [31:0] dataRam [0:127];
    int          errorCount;
    int          storeCount;
    int          expectedStores;
    int          cycleCount;

    // ======================================================================
    // clock, DUT and data memory model
    // ======================================================================

    always #10 Clk = ~Clk;

    mipsCore i_dut (
        .Clk(Clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .memReq(memReq), .memReadData(memReadData)
    );

    // combinational read, like the core expects
    assign memReadData = dataRam[memReq.addr];

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            errorCount++;
        end
    endtask

    // called at the edge, before the core updates
    task automatic checkStore();
        logic [31:0] expAddr;
        logic [31:0] expData;
        if (storeCount >= expectedStores) begin
            $display("unexpected extra store to word %0d, data 0x%08h",
                     memReq.addr, memReq.writeData);
            errorCount++;
        end else begin
            expAddr = inputWords[storeBaseIdx + 2 * storeCount];
            expData = inputWords[storeBaseIdx + 2 * storeCount + 1];
            compareValue("memReq.addr", 32'(memReq.addr), expAddr);
            compareValue("memReq.writeData", memReq.writeData, expData);
        end
        storeCount++;
        dataRam[memReq.addr] <= memReq.writeData;
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        Clk        = 1'b0;
        reset      = 1'b0;
        instr      = '0;
        errorCount = 0;
        storeCount = 0;
        cycleCount = 0;
        void'($urandom(32'h9a3d54f1));

        for (int i = 0; i < 64; i++) begin
            inputWords[i] = '0;
        end
        $readmemh("testbench/mipsCore_input.txt", inputWords);
        for (int i = 0; i < 32; i++) begin
            instrRom[i] = inputWords[i];
        end
        // random background, then the word the program loads
        for (int i = 0; i < 128; i++) begin
            dataRam[i] = $urandom();
        end
        dataRam[inputWords[preloadIdx][6:0]] = inputWords[preloadIdx + 1];
        expectedStores = int'(inputWords[storeCntIdx]);

        // reset for 4 cycles, PC sits at word 0
        repeat (4) begin
            @(posedge Clk);
            #1;
            instr = instrRom[instrAddr[6:2]];
        end
        reset = 1'b1;

        // one retired instruction per pass until the self jump is reached
        while (instrAddr !== inputWords[haltIdx] && cycleCount < timeoutLimit) begin
            @(posedge Clk);
            if (memReq.writeEn) begin
                checkStore();
            end
            #1;
            instr = instrRom[instrAddr[6:2]];
            cycleCount++;
        end

        if (cycleCount >= timeoutLimit) begin
            $display("timeout: PC never reached the halt address 0x%08h", inputWords[haltIdx]);
            errorCount++;
        end else begin
            // retire the self jump, PC must stay on it
            @(posedge Clk);
            if (memReq.writeEn) begin
                checkStore();
            end
            #1;
            instr = instrRom[instrAddr[6:2]];
            compareValue("instrAddr", instrAddr, inputWords[haltIdx]);
        end
        if (storeCount < expectedStores) begin
            $display("missing stores: only %0d of %0d seen", storeCount, expectedStores);
            errorCount++;
        end
        errorCount += i_dut.i_sva.failCount;

        $display("run finished: %0d errors, %0d of %0d stores, %0d cycles",
                 errorCount, storeCount, expectedStores, cycleCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/mipsCore_sva.sv */
// port-level checks only, sampled at the rising clock; internal datapath is not observed
`timescale 1ns/1ps
`include "mipsCore_defines.svh"

module mipsCore_sva (
    input logic                        Clk,
    input logic                        reset,
    input logic [`MIPS_DATA_WIDTH-1:0] instrAddr,
    input logic [`MIPS_DATA_WIDTH-1:0] instr,
    input mipsCtrlPkg::memReq_t        memReq
);

    // count of failed assertions
    int failCount = 0;

    logic [`MIPS_DATA_WIDTH-1:0] seqAddr;
    logic [`MIPS_DATA_WIDTH-1:0] branchAddr;
    logic [`MIPS_DATA_WIDTH-1:0] jumpAddr;

    // ======================================================================
    // PC properties
    // ======================================================================

    // candidate next fetch addresses for the word on instr
    assign seqAddr    = instrAddr + 32'd4;
    assign branchAddr = seqAddr + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jumpAddr   = {seqAddr[31:28], instr[25:0], 2'b00};

    // fetch address always word aligned
    alignedFetch: assert property (@(posedge Clk) instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instruction address not word aligned");
        end

    // PC held at zero while in reset
    pcInReset: assert property (@(posedge Clk) !reset |-> instrAddr == '0)
        else begin
            failCount++;
            $error("instruction address not zero during reset");
        end

    // next fetch is PC+4, the branch target or the jump target
    pcNextAddr: assert property (@(posedge Clk) disable iff (!reset)
        $past(reset) |-> (instrAddr == $past(seqAddr)) ||
                         (instrAddr == $past(branchAddr)) ||
                         (instrAddr == $past(jumpAddr)))
        else begin
            failCount++;
            $error("PC moved to neither PC+4, the branch target nor the jump target");
        end

    // ======================================================================
    // data memory strobe
    // ======================================================================

    storeStrobeKnown: assert property (@(posedge Clk) disable iff (!reset)
        !$isunknown(memReq.writeEn))
        else begin
            failCount++;
            $error("data memory write enable is unknown");
        end

endmodule

bind mipsCore mipsCore_sva i_sva (.*);

/* logic/mipsCore.sv */
// single-cycle core; instruction and data memories are external and must answer combinationally
`timescale 1ns/1ps
`include "mipsCore_defines.svh"

module mipsCore (
    input  logic                        Clk,
    input  logic                        reset,
    output logic [`MIPS_DATA_WIDTH-1:0] instrAddr,
    input  logic [`MIPS_DATA_WIDTH-1:0] instr,
    output mipsCtrlPkg::memReq_t        memReq,
    input  logic [`MIPS_DATA_WIDTH-1:0] memReadData
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    // field view of the fetched word
    instrFields_t                   instrView;
    ctrlSignals_t                   ctrl;
    logic [`MIPS_DATA_WIDTH-1:0]    pc;
    logic [`MIPS_DATA_WIDTH-1:0]    readDataA;
    logic [`MIPS_DATA_WIDTH-1:0]    readDataB;
    logic [`MIPS_DATA_WIDTH-1:0]    signExtImm;
    logic [`MIPS_DATA_WIDTH-1:0]    aluOperandB;
    logic [`MIPS_DATA_WIDTH-1:0]    aluResult;
    logic                           aluZero;
    logic [`MIPS_REG_IDX_WIDTH-1:0] destIdx;
    logic [`MIPS_DATA_WIDTH-1:0]    writeBack;

    assign instrView = instr;
    assign instrAddr = pc;

    // ======================================================================
    // control and fetch
    // ======================================================================

    mainDecoder i_decoder (.instr(instrView), .ctrl(ctrl));

    pcCounter i_pc (
        .Clk(Clk), .reset(reset), .instr(instrView),
        .ctrl(ctrl), .zero(aluZero), .pc(pc)
    );

    // ======================================================================
    // register read, execute, write-back
    // ======================================================================

    // rd for R-type, rt for lw
    assign destIdx = ctrl.regDst ? instrView.body.regs.low.r.rd : instrView.body.regs.rt;

    registerFile i_regs (
        .Clk(Clk), .reset(reset), .writeEn(ctrl.regWrite), .writeIdx(destIdx),
        .readIdxA(instrView.body.regs.rs), .readIdxB(instrView.body.regs.rt),
        .writeData(writeBack), .readDataA(readDataA), .readDataB(readDataB)
    );

    assign signExtImm  = {{16{instrView.body.regs.low.imm[15]}}, instrView.body.regs.low.imm};
    assign aluOperandB = ctrl.aluSrc ? signExtImm : readDataB;

    alu i_alu (
        .op(ctrl.aluOp), .operandA(readDataA), .operandB(aluOperandB),
        .result(aluResult), .zero(aluZero)
    );

    // loaded word or ALU result
    assign writeBack = ctrl.memToReg ? memReadData : aluResult;

    // byte address dropped to a word address
    assign memReq.addr      = aluResult[`MIPS_DMEM_ADDR_WIDTH+1:2];
    assign memReq.writeData = readDataB;
    assign memReq.writeEn   = ctrl.memWrite;

endmodule

/* logic/mainDecoder.sv */
// purely combinational; unknown opcodes decode to a no-op that only advances the PC
`timescale 1ns/1ps

module mainDecoder (
    input  mipsIsaPkg::instrFields_t  instr,
    output mipsCtrlPkg::ctrlSignals_t ctrl
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    // ======================================================================
    // opcode and funct decode
    // ======================================================================

    always_comb begin
        // safe defaults, nothing written, sequential fetch
        ctrl          = '0;
        ctrl.aluOp    = aluAdd;

        case (instr.opcode)
            opRType: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                // funct picks the operation
                case (instr.body.regs.low.r.funct)
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    // add and any unknown funct
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opLw: begin
                // base plus offset
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opBeq: begin
                // equal operands give a zero difference
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            opJ: begin
                ctrl.jump     = 1'b1;
            end
            default: begin
                // keep the defaults
                ctrl.aluOp    = aluAdd;
            end
        endcase
    end

endmodule

/* logic/pcCounter.sv */
// PC is a byte address that always stays word aligned; jump overrides a taken branch
`timescale 1ns/1ps
`include "mipsCore_defines.svh"

module pcCounter (
    input  logic                        Clk,
    input  logic                        reset,
    input  mipsIsaPkg::instrFields_t    instr,
    input  mipsCtrlPkg::ctrlSignals_t   ctrl,
    input  logic                        zero,
    output logic [`MIPS_DATA_WIDTH-1:0] pc
);

    logic [`MIPS_DATA_WIDTH-1:0] pcPlus4;
    logic [`MIPS_DATA_WIDTH-1:0] branchTarget;
    logic [`MIPS_DATA_WIDTH-1:0] jumpTarget;
    logic [`MIPS_DATA_WIDTH-1:0] nextPc;

    // ======================================================================
    // next address
    // ======================================================================

    assign pcPlus4 = pc + `MIPS_PC_STEP;

    // word offset, sign extended and scaled to bytes
    assign branchTarget = pcPlus4 + {{14{instr.body.regs.low.imm[15]}},
                                     instr.body.regs.low.imm, 2'b00};

    // region bits kept from PC+4
    assign jumpTarget = {pcPlus4[31:28], instr.body.target, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && zero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // ======================================================================
    // PC register
    // ======================================================================

    // one instruction retires per edge
    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* logic/registerFile.sv */
// reads are combinational and see the old value during a same-cycle write; r0 is not stored
`timescale 1ns/1ps
`include "mipsCore_defines.svh"

module registerFile (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           writeEn,
    input  logic [`MIPS_REG_IDX_WIDTH-1:0] writeIdx,
    input  logic [`MIPS_REG_IDX_WIDTH-1:0] readIdxA,
    input  logic [`MIPS_REG_IDX_WIDTH-1:0] readIdxB,
    input  logic [`MIPS_DATA_WIDTH-1:0]    writeData,
    output logic [`MIPS_DATA_WIDTH-1:0]    readDataA,
    output logic [`MIPS_DATA_WIDTH-1:0]    readDataB
);

    // registers 1 to 31 only
    logic [`MIPS_DATA_WIDTH-1:0] regs [1:`MIPS_REG_COUNT-1];

    // ======================================================================
    // write port
    // ======================================================================

    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeIdx != '0)) begin
            // writes to r0 dropped here
            regs[writeIdx] <= writeData;
        end
    end

    // ======================================================================
    // read ports
    // ======================================================================

    // r0 reads as constant zero
    always_comb begin
        if (readIdxA == '0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readIdxA];
        end
    end

    always_comb begin
        if (readIdxB == '0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readIdxB];
        end
    end

endmodule

/* logic/alu.sv */
// 32-bit combinational ALU, no overflow trap; slt compares as signed
`timescale 1ns/1ps
`include "mipsCore_defines.svh"

module alu (
    input  mipsCtrlPkg::aluOp_t         op,
    input  logic [`MIPS_DATA_WIDTH-1:0] operandA,
    input  logic [`MIPS_DATA_WIDTH-1:0] operandB,
    output logic [`MIPS_DATA_WIDTH-1:0] result,
    output logic                        zero
);
    import mipsCtrlPkg::*;

    // ======================================================================
    // operation select
    // ======================================================================

    always_comb begin
        case (op)
            aluSub: result = operandA - operandB;
            aluAnd: result = operandA & operandB;
            aluOr:  result = operandA | operandB;
            aluSlt: begin
                // 1 or 0, signed compare
                result = ($signed(operandA) < $signed(operandB)) ?
                         `MIPS_DATA_WIDTH'd1 : '0;
            end
            // add, also the fallback
            default: result = operandA + operandB;
        endcase
    end

    // beq tests the difference
    assign zero = (result == '0);

endmodule

/* logic/mipsCtrlPkg.sv */
// datapath control types; memory request carries no read strobe since reads are combinational
`include "mipsCore_defines.svh"

package mipsCtrlPkg;

    // ======================================================================
    // ALU
    // ======================================================================

    // only the operations the decoded subset can select
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOp_t;

    // ======================================================================
    // control and memory
    // ======================================================================

    // steering bits from the decoder, one set per instruction
    typedef struct packed {
        // write rd instead of rt
        logic   regDst;
        // second operand from immediate
        logic   aluSrc;
        // write-back from data memory
        logic   memToReg;
        logic   regWrite;
        logic   memWrite;
        logic   branch;
        logic   jump;
        aluOp_t aluOp;
    } ctrlSignals_t;

    // word-addressed request to the external data memory
    typedef struct packed {
        logic [`MIPS_DMEM_ADDR_WIDTH-1:0] addr;
        logic [`MIPS_DATA_WIDTH-1:0]      writeData;
        // level write strobe, sampled at the rising edge
        logic                             writeEn;
    } memReq_t;

endpackage

/* logic/mipsIsaPkg.sv */
// instruction encodings for the supported MIPS subset only; other opcodes are not named here
`include "mipsCore_defines.svh"

package mipsIsaPkg;

    // primary opcode, bits 31..26
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    // R-type function field, bits 5..0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    // low half of an R-type word
    typedef struct packed {
        logic [`MIPS_REG_IDX_WIDTH-1:0] rd;
        logic [4:0]                     shamt;
        funct_t                         funct;
    } rFields_t;

    // same 16 bits read as immediate for I-type
    typedef union packed {
        rFields_t    r;
        logic [15:0] imm;
    } lowHalf_t;

    typedef struct packed {
        logic [`MIPS_REG_IDX_WIDTH-1:0] rs;
        logic [`MIPS_REG_IDX_WIDTH-1:0] rt;
        lowHalf_t                       low;
    } regFields_t;

    // 26-bit body, register fields or jump target
    typedef union packed {
        regFields_t  regs;
        logic [25:0] target;
    } body_t;

    typedef struct packed {
        opcode_t opcode;
        body_t   body;
    } instrFields_t;

endpackage

/* logic/mipsCore_defines.svh */
// global macros shared by all core files; data memory depth is fixed at 128 words
`ifndef MIPS_CORE_DEFINES_SVH
`define MIPS_CORE_DEFINES_SVH

// ======================================================================
// datapath sizes
// ======================================================================

// word width of registers, ALU and memories
`define MIPS_DATA_WIDTH 32

// architectural register count, r0 hardwired to zero
`define MIPS_REG_COUNT 32
`define MIPS_REG_IDX_WIDTH 5

// data memory word address, taken from ALU result bits 8..2
`define MIPS_DMEM_ADDR_WIDTH 7

// byte step between sequential instructions
`define MIPS_PC_STEP 4

`endif
